//--- cache_macros.svh
// cache geometry and address widths; include wherever a size is needed
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ------------------------------
// word and line
// ------------------------------
`define CACHE_WORD_W      32   // processor word
`define CACHE_WORDS       4    // words per line
`define CACHE_LINE_W      128  // one memory block

// ------------------------------
// organisation
// ------------------------------
`define CACHE_SETS        4
`define CACHE_WAYS        2

// ------------------------------
// address split
// ------------------------------
`define CACHE_ADDR_W      30   // word address from the processor
`define CACHE_BLK_ADDR_W  28   // block address to memory
`define CACHE_OFF_W       2    // word within the line
`define CACHE_IDX_W       2    // set index
`define CACHE_TAG_W       26   // what is left above index and offset

`endif

//--- cache_pkg.sv
// types shared by the cache RTL and the testbench; import with cache_pkg::*
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

	// ------------------------------
	// data
	// ------------------------------
	typedef logic [`CACHE_WORD_W-1:0] word_t;
	typedef word_t [`CACHE_WORDS-1:0] line_t;  // word 0 in the low bits

	// ------------------------------
	// addressing
	// ------------------------------
	typedef logic [`CACHE_TAG_W-1:0] tag_entry_t;
	typedef logic [`CACHE_IDX_W-1:0] set_idx_t;
	typedef logic [`CACHE_OFF_W-1:0] word_off_t;
	typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

	typedef struct packed {
		tag_entry_t tag;
		set_idx_t   idx;
		word_off_t  off;
	} word_addr_t;  // processor word address

	typedef struct packed {
		tag_entry_t tag;
		set_idx_t   idx;
	} blk_addr_t;  // memory block address

	// ------------------------------
	// requests
	// ------------------------------
	typedef struct packed {
		logic       read;
		logic       write;
		word_addr_t addr;
		word_t      wdata;
	} proc_req_t;

	typedef struct packed {
		logic      read;
		logic      write;
		blk_addr_t addr;
		line_t     wdata;
	} mem_req_t;

	typedef enum logic [1:0] {
		st_ready      = 2'd0,
		st_write_back = 2'd1,
		st_refill     = 2'd2
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- set_array.sv
// one entry per way per set, async read of a whole set; used for tags and for lines
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module set_array
	import cache_pkg::*;
#(
	parameter type entry_t = logic
) (
	input  wire logic                         clk,
	input  wire logic                         wr_en,
	input  wire way_t                         wr_way,
	input  wire set_idx_t                     wr_set,
	input  wire entry_t                       wr_data,
	input  wire set_idx_t                     rd_set,
	output entry_t [`CACHE_WAYS-1:0]          rd_entries
);

	// ------------------------------
	// storage
	// ------------------------------
	entry_t [`CACHE_WAYS-1:0] mem_q [`CACHE_SETS];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_q[wr_set][wr_way] <= wr_data;  // one way only
		end
	end

	// both ways of the set, same cycle
	assign rd_entries = mem_q[rd_set];

	// ------------------------------
	// checks
	// ------------------------------
	// an unknown way would silently corrupt one of the two entries
	a_wr_way_known: assert property (
		@(posedge clk) wr_en |-> !$isunknown(wr_way)
	) else $error("set_array: write with unknown way");

endmodule

`default_nettype wire

//--- way_lookup.sv
// tag compare, hit way and victim choice; keeps the valid and MRU bits per set
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module way_lookup
	import cache_pkg::*;
(
	input  wire logic                           clk,
	input  wire logic                           rst_n,
	input  wire set_idx_t                       set_idx,
	input  wire tag_entry_t                     req_tag,
	input  wire tag_entry_t [`CACHE_WAYS-1:0]   stored_tags,
	input  wire logic                           access,
	input  wire logic                           fill,
	input  wire way_t                           fill_way,
	output logic                                hit,
	output way_t                                hit_way,
	output way_t                                victim_way,
	output logic                                victim_valid
);

	logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid_q;
	way_t [`CACHE_SETS-1:0]                  mru_q;    // last way touched per set
	logic [`CACHE_WAYS-1:0]                  match;

	// ------------------------------
	// compare
	// ------------------------------
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			match[w] = valid_q[set_idx][w] && (stored_tags[w] == req_tag);
			if (match[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	assign hit = |match;

	// ------------------------------
	// victim
	// ------------------------------
	// an empty way wins, lowest first; else the way not used last
	always_comb begin
		victim_way = ~mru_q[set_idx];
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (!valid_q[set_idx][w]) begin
				victim_way = way_t'(w);
			end
		end
	end

	assign victim_valid = valid_q[set_idx][victim_way];

	// ------------------------------
	// state
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			mru_q   <= '0;
		end else if (fill) begin
			valid_q[set_idx][fill_way] <= 1'b1;
			mru_q[set_idx]             <= fill_way;  // new line counts as used
		end else if (access) begin
			mru_q[set_idx] <= hit_way;
		end
	end

	// a refill only ever lands on a missing tag, so a line is never held twice
	a_single_hit: assert property (
		@(posedge clk) disable iff (!rst_n) $onehot0(match)
	) else $error("way_lookup: tag matches in more than one way");

endmodule

`default_nettype wire

//--- cache_ctrl.sv
// ready / write-back / refill FSM; stalls the processor and drives memory and array writes
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
	import cache_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire proc_req_t   proc_req,
	input  wire logic        hit,
	input  wire way_t        hit_way,
	input  wire way_t        victim_way,
	input  wire logic        victim_valid,
	input  wire tag_entry_t  victim_tag,
	input  wire line_t       victim_line,
	input  wire line_t       hit_line,
	input  wire line_t       mem_rdata,
	input  wire logic        mem_ready,
	output mem_req_t         mem_req,
	output logic             proc_stall,
	output word_t            proc_rdata,
	output logic             access,
	output logic             fill,
	output way_t             fill_way,
	output logic             tag_wr_en,
	output logic             data_wr_en,
	output way_t             wr_way,
	output tag_entry_t       tag_wr_data,
	output line_t            line_wr_data
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	logic        req_active;
	line_t       merged_line;  // hit line with the write word dropped in

	assign req_active = proc_req.read | proc_req.write;

	// read data straight from the hit way
	assign proc_rdata  = hit_line[proc_req.addr.off];
	assign tag_wr_data = proc_req.addr.tag;
	assign fill_way    = victim_way;  // victim stays put for the whole miss

	always_comb begin
		merged_line = hit_line;
		merged_line[proc_req.addr.off] = proc_req.wdata;
	end

	// ------------------------------
	// next state and outputs
	// ------------------------------
	always_comb begin
		state_d      = state_q;
		mem_req      = '0;
		proc_stall   = 1'b0;
		access       = 1'b0;
		fill         = 1'b0;
		tag_wr_en    = 1'b0;
		data_wr_en   = 1'b0;
		wr_way       = hit_way;
		line_wr_data = merged_line;

		case (state_q)
			st_ready: begin
				if (req_active && hit) begin
					access     = 1'b1;
					data_wr_en = proc_req.write;  // word lands at the edge
				end else if (req_active) begin
					proc_stall = 1'b1;
					state_d    = victim_valid ? st_write_back : st_refill;
				end
			end

			st_write_back: begin
				proc_stall         = 1'b1;
				mem_req.write      = 1'b1;
				mem_req.addr.tag   = victim_tag;
				mem_req.addr.idx   = proc_req.addr.idx;
				mem_req.wdata      = victim_line;
				if (mem_ready) begin
					state_d = st_refill;
				end
			end

			st_refill: begin
				proc_stall       = 1'b1;
				mem_req.read     = 1'b1;
				mem_req.addr.tag = proc_req.addr.tag;
				mem_req.addr.idx = proc_req.addr.idx;
				wr_way           = victim_way;
				line_wr_data     = mem_rdata;
				if (mem_ready) begin
					tag_wr_en  = 1'b1;
					data_wr_en = 1'b1;
					fill       = 1'b1;
					state_d    = st_ready;  // request hits on the next cycle
				end
			end

			default: begin
				state_d = st_ready;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= st_ready;
		end else begin
			state_q <= state_d;
		end
	end

	// ------------------------------
	// checks
	// ------------------------------
	a_rd_wr_excl: assert property (
		@(posedge clk) disable iff (!rst_n) !(mem_req.read && mem_req.write)
	) else $error("cache_ctrl: memory read and write together");

	// a waiting memory request must not move, which needs the processor to hold too
	a_mem_req_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		((mem_req.read || mem_req.write) && !mem_ready) |=> $stable(mem_req)
	) else $error("cache_ctrl: memory request changed before mem_ready");

endmodule

`default_nettype wire

//--- cache_top.sv
// 2-way write-back data cache; processor request in, line-wide memory port out
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_top
	import cache_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire proc_req_t  proc_req,
	output word_t           proc_rdata,
	output logic            proc_stall,
	output mem_req_t        mem_req,
	input  wire line_t      mem_rdata,
	input  wire logic       mem_ready
);

	// ------------------------------
	// geometry checks
	// ------------------------------
	if ($bits(line_t) != `CACHE_LINE_W) begin : g_line_chk
		$error("cache_top: line type does not match CACHE_LINE_W");
	end
	if ($bits(word_addr_t) != `CACHE_ADDR_W) begin : g_addr_chk
		$error("cache_top: address split does not match CACHE_ADDR_W");
	end
	if ($bits(blk_addr_t) != `CACHE_BLK_ADDR_W) begin : g_blk_chk
		$error("cache_top: block address does not match CACHE_BLK_ADDR_W");
	end

	tag_entry_t [`CACHE_WAYS-1:0] stored_tags;
	line_t [`CACHE_WAYS-1:0]      stored_lines;

	logic       hit, victim_valid, access, fill;
	way_t       hit_way, victim_way, fill_way, wr_way;
	logic       tag_wr_en, data_wr_en;
	tag_entry_t tag_wr_data;
	line_t      line_wr_data;

	// address fields
	tag_entry_t req_tag;
	set_idx_t   set_idx;

	assign req_tag = proc_req.addr.tag;
	assign set_idx = proc_req.addr.idx;

	// ------------------------------
	// lookup and control
	// ------------------------------
	way_lookup u_lookup (
		.clk          (clk),
		.rst_n        (rst_n),
		.set_idx      (set_idx),
		.req_tag      (req_tag),
		.stored_tags  (stored_tags),
		.access       (access),
		.fill         (fill),
		.fill_way     (fill_way),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_valid (victim_valid)
	);

	cache_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.proc_req     (proc_req),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_valid (victim_valid),
		.victim_tag   (stored_tags[victim_way]),
		.victim_line  (stored_lines[victim_way]),
		.hit_line     (stored_lines[hit_way]),
		.mem_rdata    (mem_rdata),
		.mem_ready    (mem_ready),
		.mem_req      (mem_req),
		.proc_stall   (proc_stall),
		.proc_rdata   (proc_rdata),
		.access       (access),
		.fill         (fill),
		.fill_way     (fill_way),
		.tag_wr_en    (tag_wr_en),
		.data_wr_en   (data_wr_en),
		.wr_way       (wr_way),
		.tag_wr_data  (tag_wr_data),
		.line_wr_data (line_wr_data)
	);

	// ------------------------------
	// storage
	// ------------------------------
	set_array #(.entry_t(tag_entry_t)) u_tag_array (
		.clk        (clk),
		.wr_en      (tag_wr_en),
		.wr_way     (wr_way),
		.wr_set     (set_idx),
		.wr_data    (tag_wr_data),
		.rd_set     (set_idx),
		.rd_entries (stored_tags)
	);

	set_array #(.entry_t(line_t)) u_data_array (
		.clk        (clk),
		.wr_en      (data_wr_en),
		.wr_way     (wr_way),
		.wr_set     (set_idx),
		.wr_data    (line_wr_data),
		.rd_set     (set_idx),
		.rd_entries (stored_lines)
	);

endmodule

`default_nettype wire

//--- tb_mem_model.sv
// slow line memory for the cache testbench; random ready delay, address pattern until written
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module tb_mem_model
	import cache_pkg::*;
#(
	parameter logic [31:0] seed = 32'h1
) (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire mem_req_t mem_req,
	output line_t         mem_rdata,
	output logic          mem_ready
);

	localparam int max_delay = 6;  // cycles

	line_t                        store [logic [`CACHE_BLK_ADDR_W-1:0]];  // written lines only
	logic [`CACHE_BLK_ADDR_W-1:0] blk;
	logic [31:0]                  rng;
	int                           delay_left;
	logic                         busy;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// word at word address A reads as A with 2'b10 on top
	function automatic line_t pattern_line(input logic [`CACHE_BLK_ADDR_W-1:0] b);
		line_t l;
		for (int w = 0; w < `CACHE_WORDS; w++) begin
			l[w] = {2'b10, b, w[`CACHE_OFF_W-1:0]};
		end
		return l;
	endfunction

	initial begin
		mem_rdata  = '0;
		mem_ready  = 1'b0;
		rng        = seed;
		delay_left = 0;
		busy       = 1'b0;
	end

	// ------------------------------
	// request handling
	// ------------------------------
	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_ready <= 1'b0;
			busy = 1'b0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0;  // taken at the last rising edge
			busy = 1'b0;
		end else if (mem_req.read || mem_req.write) begin
			blk = mem_req.addr;
			if (!busy) begin
				rng        = xorshift32(rng);
				delay_left = 1 + int'(rng % max_delay);
				busy       = 1'b1;
			end
			delay_left--;
			if (delay_left == 0) begin
				if (mem_req.write) begin
					store[blk] = mem_req.wdata;  // whole line replaced
				end else if (store.exists(blk)) begin
					mem_rdata <= store[blk];
				end else begin
					mem_rdata <= pattern_line(blk);
				end
				mem_ready <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_cache.sv
// testbench for the data cache; replays cache_tests.txt against the slow memory model
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module tb_cache
	import cache_pkg::*;
();

	localparam int          clk_period = 8;
	localparam int          max_wait   = 64;  // cycles allowed for one request to complete
	localparam logic [31:0] mem_seed   = 32'hf64f6ea3;

	logic      clk;
	logic      rst_n;
	proc_req_t proc_req;
	word_t     proc_rdata;
	logic      proc_stall;
	mem_req_t  mem_req;
	line_t     mem_rdata;
	logic      mem_ready;

	int   n_tests;
	int   n_pass;
	int   n_errors;
	logic timed_out;

	cache_top uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.proc_req   (proc_req),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	tb_mem_model #(.seed(mem_seed)) u_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	// one idle cycle with no stall and no memory request
	task automatic check_idle();
		@(negedge clk);
		proc_req = '0;
		#(clk_period / 4);
		if (proc_stall) begin
			$display("** Error at %0t: proc_stall high with no request", $time);
			n_errors++;
		end
		if (mem_req.read || mem_req.write) begin
			$display("** Error at %0t: memory request active with no miss pending", $time);
			n_errors++;
		end
	endtask

	task automatic wait_unstalled(input int test_no, output int stall_cycles);
		stall_cycles = 0;
		#(clk_period / 4);  // let the falling edge drive settle
		while (proc_stall && stall_cycles < max_wait) begin
			@(negedge clk);
			#(clk_period / 4);
			stall_cycles++;
		end
		if (proc_stall) begin
			$display("timeout: test %0d still stalled after %0d cycles", test_no, max_wait);
			timed_out = 1'b1;
			n_errors++;
		end
	endtask

	task automatic run_test(input int test_no, input int op_ch, input logic [31:0] addr,
			input word_t wdata, input word_t expected, input int want_hit);
		int    stall_cycles;
		int    errors_before;
		word_t got;
		errors_before = n_errors;
		got = '0;
		@(negedge clk);
		proc_req.read  = (op_ch == "R");
		proc_req.write = (op_ch == "W");
		proc_req.addr  = addr[`CACHE_ADDR_W-1:0];
		proc_req.wdata = wdata;
		wait_unstalled(test_no, stall_cycles);
		if (!timed_out) begin
			got = proc_rdata;  // held until the rising edge that completes the access
			if (proc_req.read && got !== expected) begin
				$display("** Error at %0t: test %0d read %h at %h, expected %h",
					$time, test_no, got, addr, expected);
				n_errors++;
			end
			if ((stall_cycles == 0) != (want_hit != 0)) begin
				$display("** Error at %0t: test %0d expected a %s, stalled %0d cycles",
					$time, test_no, (want_hit != 0) ? "hit" : "miss", stall_cycles);
				n_errors++;
			end
			check_idle();
		end
		n_tests++;
		if (n_errors == errors_before) begin
			n_pass++;
		end
		$display("test %0d: %c %h -> %h, %0d stall cycles, %s", test_no, op_ch, addr, got,
			stall_cycles, (n_errors == errors_before) ? "ok" : "bad");
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		int          fd;
		int          n_fields;
		int          test_no;
		int          op_ch;
		int          want_hit;
		logic [31:0] addr;
		word_t       wdata;
		word_t       expected;
		string       text;

		proc_req  = '0;
		rst_n     = 1'b0;
		n_tests   = 0;
		n_pass    = 0;
		n_errors  = 0;
		timed_out = 1'b0;
		test_no   = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		repeat (4) check_idle();

		fd = $fopen("cache_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open cache_tests.txt");
			n_errors++;
		end else begin
			while (!timed_out && $fgets(text, fd) != 0) begin
				if (text.len() < 2 || text[0] == "#") begin
					continue;
				end
				n_fields = $sscanf(text, "%c %h %h %h %d", op_ch, addr, wdata, expected,
					want_hit);
				test_no++;
				if (n_fields != 5 || (op_ch != "R" && op_ch != "W")) begin
					$display("test %0d: line in cache_tests.txt cannot be read", test_no);
					n_errors++;
				end else begin
					run_test(test_no, op_ch, addr, wdata, expected, want_hit);
				end
			end
			$fclose(fd);
		end

		$display("%0d tests run, %0d passed, %0d errors", n_tests, n_pass, n_errors);
		if (n_errors == 0 && !timed_out && n_tests > 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cache_tests.txt
# op (R/W), word address, write data, expected read data (ignored for W), 1 = hit / 0 = miss
# word address A holds {2'b10, A} in memory until written; set = A[3:2], tag = A[29:4]
R 00000000 00000000 80000000 0
R 00000002 00000000 80000002 1
W 00000001 deadbeef 00000000 1
R 00000001 00000000 deadbeef 1
R 00000000 00000000 80000000 1
R 00000003 00000000 80000003 1
R 00000010 00000000 80000010 0
R 00000020 00000000 80000020 0
R 00000001 00000000 deadbeef 0
R 00000004 00000000 80000004 0
R 00000014 00000000 80000014 0
W 00000016 12345678 00000000 1
R 00000005 00000000 80000005 1
R 00000024 00000000 80000024 0
R 00000006 00000000 80000006 1
R 00000016 00000000 12345678 0
W 3ffffffb cafef00d 00000000 0
R 3ffffff8 00000000 bffffff8 1
R 0000002b 00000000 8000002b 0
R 0000003b 00000000 8000003b 0
R 3ffffffb 00000000 cafef00d 0

//--- files.f
+incdir+.
cache_pkg.sv
set_array.sv
way_lookup.sv
cache_ctrl.sv
cache_top.sv
tb_mem_model.sv
tb_cache.sv

//--- Bender.yml
package:
  name: cache

export_include_dirs:
  - .

sources:
  - files:
      - cache_pkg.sv
      - set_array.sv
      - way_lookup.sv
      - cache_ctrl.sv
      - cache_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_cache.sv
